//--- source/sram_params.svh
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// byte address and data word widths
`define SRAM_ADDR_WIDTH 32
`define SRAM_DATA_WIDTH 32
// one strobe bit per data byte
`define SRAM_STRB_WIDTH (`SRAM_DATA_WIDTH / 8)
// low address bits that select a byte inside the word
`define SRAM_BYTE_OFFSET 2

// 256 words, 1 KiB of storage
`define SRAM_DEPTH_LOG2 8
// cycles a request sits in the delay stage
`define SRAM_ACCESS_LATENCY 2

`endif

//--- source/sram_pkg.sv
`default_nettype none

package sram_pkg;

    // axi response code on R and B
    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // request kind travelling down the pipeline
    // decides R or B routing at the end
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_t;

endpackage

`default_nettype wire

//--- source/sram_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_params.svh"

// request between accept, delay and array stages
interface sram_req_if;
    logic                        valid;
    logic                        ready;
    sram_pkg::mem_op_t           op;
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
    logic [`SRAM_DATA_WIDTH-1:0] wdata;
    // byte enables, ignored on reads
    logic [`SRAM_STRB_WIDTH-1:0] wstrb;

    modport driver   (output valid, op, addr, wdata, wstrb, input ready);
    modport receiver (input valid, op, addr, wdata, wstrb, output ready);
endinterface

// result from the array to the response stage
interface sram_rsp_if;
    logic                        valid;
    logic                        ready;
    sram_pkg::mem_op_t           op;
    logic [`SRAM_DATA_WIDTH-1:0] rdata;
    sram_pkg::axi_resp_t         resp;

    modport driver   (output valid, op, rdata, resp, input ready);
    modport receiver (input valid, op, rdata, resp, output ready);
endinterface

`default_nettype wire

//--- source/axi_lite_accept.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_params.svh"

module axi_lite_accept (
    input  wire                         clk,
    input  wire                         reset,
    input  wire [`SRAM_ADDR_WIDTH-1:0]  araddr,
    input  wire                         arvalid,
    output logic                        arready,
    input  wire [`SRAM_ADDR_WIDTH-1:0]  awaddr,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire [`SRAM_DATA_WIDTH-1:0]  wdata,
    input  wire [`SRAM_STRB_WIDTH-1:0]  wstrb,
    input  wire                         wvalid,
    output logic                        wready,
    sram_req_if.driver                  req
);

    // single output slot
    logic                        slot_valid;
    sram_pkg::mem_op_t           slot_op;
    logic [`SRAM_ADDR_WIDTH-1:0] slot_addr;
    logic [`SRAM_DATA_WIDTH-1:0] slot_wdata;
    logic [`SRAM_STRB_WIDTH-1:0] slot_wstrb;

    // aw and w latched on their own, either order
    logic                        aw_full;
    logic [`SRAM_ADDR_WIDTH-1:0] aw_addr_q;
    logic                        w_full;
    logic [`SRAM_DATA_WIDTH-1:0] w_data_q;
    logic [`SRAM_STRB_WIDTH-1:0] w_strb_q;

    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic aw_have;
    logic w_have;
    logic slot_free;
    logic load_rd;
    logic load_wr;
    logic slot_valid_next;
    logic aw_full_next;
    logic w_full_next;

    always_comb begin
        ar_hs = arvalid && arready;
        aw_hs = awvalid && awready;
        w_hs  = wvalid && wready;
        // held half or arriving this edge
        aw_have = aw_full || aw_hs;
        w_have  = w_full || w_hs;
        // empty, or draining into the delay stage now
        slot_free = !slot_valid || req.ready;
        // read wins the slot when both are ready
        load_rd = ar_hs && slot_free;
        load_wr = !ar_hs && aw_have && w_have && slot_free;
        slot_valid_next = load_rd || load_wr || (slot_valid && !req.ready);
        aw_full_next    = aw_have && !load_wr;
        w_full_next     = w_have && !load_wr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
            aw_full    <= 1'b0;
            w_full     <= 1'b0;
            arready    <= 1'b0;
            awready    <= 1'b0;
            wready     <= 1'b0;
        end else begin
            slot_valid <= slot_valid_next;
            aw_full    <= aw_full_next;
            w_full     <= w_full_next;
            // readies only while the slot will be free
            arready    <= !slot_valid_next;
            awready    <= !slot_valid_next && !aw_full_next;
            wready     <= !slot_valid_next && !w_full_next;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= awaddr;
        end
        if (w_hs) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (load_rd) begin
            slot_op    <= sram_pkg::OP_READ;
            slot_addr  <= araddr;
            slot_wdata <= '0;
            slot_wstrb <= '0;
        end else if (load_wr) begin
            // take each half from the latch or straight off the bus
            slot_op    <= sram_pkg::OP_WRITE;
            slot_addr  <= aw_full ? aw_addr_q : awaddr;
            slot_wdata <= w_full ? w_data_q : wdata;
            slot_wstrb <= w_full ? w_strb_q : wstrb;
        end
    end

    assign req.valid = slot_valid;
    assign req.op    = slot_op;
    assign req.addr  = slot_addr;
    assign req.wdata = slot_wdata;
    assign req.wstrb = slot_wstrb;

endmodule

`default_nettype wire

//--- source/access_delay.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_params.svh"

module access_delay (
    input  wire           clk,
    input  wire           reset,
    sram_req_if.receiver  up,
    sram_req_if.driver    down
);

    localparam int LATENCY   = `SRAM_ACCESS_LATENCY;
    localparam int CNT_WIDTH = $clog2(LATENCY + 1);

    logic                        full;
    logic [CNT_WIDTH-1:0]        count;
    sram_pkg::mem_op_t           op_q;
    logic [`SRAM_ADDR_WIDTH-1:0] addr_q;
    logic [`SRAM_DATA_WIDTH-1:0] wdata_q;
    logic [`SRAM_STRB_WIDTH-1:0] wstrb_q;
    logic                        done;
    logic                        drain;
    logic                        take;

    // access time elapsed
    assign done  = (count == CNT_WIDTH'(LATENCY));
    assign drain = full && done && down.ready;
    // one request in flight, refill while it leaves
    assign up.ready = !full || drain;
    assign take     = up.valid && up.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full  <= 1'b0;
            count <= '0;
        end else if (take) begin
            full  <= 1'b1;
            count <= '0;
        end else if (drain) begin
            full <= 1'b0;
        end else if (full && !done) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q    <= up.op;
            addr_q  <= up.addr;
            wdata_q <= up.wdata;
            wstrb_q <= up.wstrb;
        end
    end

    // offered only once the count is done, held until taken
    assign down.valid = full && done;
    assign down.op    = op_q;
    assign down.addr  = addr_q;
    assign down.wdata = wdata_q;
    assign down.wstrb = wstrb_q;

endmodule

`default_nettype wire

//--- source/sram_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_params.svh"

module sram_array (
    input  wire           clk,
    input  wire           reset,
    sram_req_if.receiver  req,
    sram_rsp_if.driver    rsp
);

    localparam int DEPTH   = 1 << `SRAM_DEPTH_LOG2;
    localparam int IDX_LSB = `SRAM_BYTE_OFFSET;
    localparam int IDX_MSB = `SRAM_BYTE_OFFSET + `SRAM_DEPTH_LOG2 - 1;

    logic [`SRAM_DATA_WIDTH-1:0] mem [DEPTH];
    logic [`SRAM_DEPTH_LOG2-1:0] index;
    logic                        in_range;
    logic                        take;
    logic                        rsp_valid;
    sram_pkg::mem_op_t           op_q;
    logic [`SRAM_DATA_WIDTH-1:0] rdata_q;
    sram_pkg::axi_resp_t         resp_q;

    // word index above the byte offset
    assign index = req.addr[IDX_MSB:IDX_LSB];
    // any bit above the array means out of range
    assign in_range = ~|req.addr[`SRAM_ADDR_WIDTH-1:IDX_MSB+1];

    assign req.ready = !rsp_valid || rsp.ready;
    assign take      = req.valid && req.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (take) begin
            rsp_valid <= 1'b1;
        end else if (rsp.ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q <= req.op;
            if (!in_range) begin
                // slverr, zero data, memory left alone
                rdata_q <= '0;
                resp_q  <= sram_pkg::RESP_SLVERR;
            end else if (req.op == sram_pkg::OP_WRITE) begin
                for (int i = 0; i < `SRAM_STRB_WIDTH; i++) begin
                    if (req.wstrb[i]) begin
                        mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
                    end
                end
                rdata_q <= '0;
                resp_q  <= sram_pkg::RESP_OKAY;
            end else begin
                rdata_q <= mem[index];
                resp_q  <= sram_pkg::RESP_OKAY;
            end
        end
    end

    assign rsp.valid = rsp_valid;
    assign rsp.op    = op_q;
    assign rsp.rdata = rdata_q;
    assign rsp.resp  = resp_q;

endmodule

`default_nettype wire

//--- source/axi_lite_respond.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_params.svh"

module axi_lite_respond (
    input  wire                         clk,
    input  wire                         reset,
    sram_rsp_if.receiver                rsp,
    output logic [`SRAM_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  wire                         rready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  wire                         bready
);

    logic r_done;
    logic b_done;
    logic take;
    logic is_read;

    // channel handshakes this cycle
    assign r_done = rvalid && rready;
    assign b_done = bvalid && bready;

    // one result held at a time keeps issue order across R and B
    assign rsp.ready = (!rvalid && !bvalid) || r_done || b_done;
    assign take      = rsp.valid && rsp.ready;
    assign is_read   = (rsp.op == sram_pkg::OP_READ);

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            // drop first, a new result may set it again
            if (r_done) begin
                rvalid <= 1'b0;
            end
            if (b_done) begin
                bvalid <= 1'b0;
            end
            if (take && is_read) begin
                rvalid <= 1'b1;
            end
            if (take && !is_read) begin
                bvalid <= 1'b1;
            end
        end
    end

    // channel payload, stable while valid is up
    always_ff @(posedge clk) begin
        if (take && is_read) begin
            rdata <= rsp.rdata;
            rresp <= rsp.resp;
        end
        if (take && !is_read) begin
            bresp <= rsp.resp;
        end
    end

endmodule

`default_nettype wire

//--- source/axi_lite_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_params.svh"

module axi_lite_sram (
    input  wire                         clk,
    input  wire                         reset,
    // read address
    input  wire [`SRAM_ADDR_WIDTH-1:0]  araddr,
    input  wire                         arvalid,
    output logic                        arready,
    // read data
    output logic [`SRAM_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  wire                         rready,
    // write address
    input  wire [`SRAM_ADDR_WIDTH-1:0]  awaddr,
    input  wire                         awvalid,
    output logic                        awready,
    // write data
    input  wire [`SRAM_DATA_WIDTH-1:0]  wdata,
    input  wire [`SRAM_STRB_WIDTH-1:0]  wstrb,
    input  wire                         wvalid,
    output logic                        wready,
    // write response
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  wire                         bready
);

    // accept -> delay -> array -> respond
    sram_req_if req_a ();
    sram_req_if req_d ();
    sram_rsp_if rsp ();

    axi_lite_accept u_accept (
        .clk     (clk),
        .reset   (reset),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .req     (req_a)
    );

    access_delay u_delay (
        .clk   (clk),
        .reset (reset),
        .up    (req_a),
        .down  (req_d)
    );

    sram_array u_array (
        .clk   (clk),
        .reset (reset),
        .req   (req_d),
        .rsp   (rsp)
    );

    axi_lite_respond u_respond (
        .clk    (clk),
        .reset  (reset),
        .rsp    (rsp),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready)
    );

endmodule

`default_nettype wire

//--- bench/axi_lite_sram_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_params.svh"

module axi_lite_sram_tb;

    localparam int TIMEOUT    = 200;
    localparam int NAME_BYTES = 24;

    logic                        clk;
    logic                        reset;
    logic [`SRAM_ADDR_WIDTH-1:0] araddr;
    logic                        arvalid;
    logic                        arready;
    logic [`SRAM_DATA_WIDTH-1:0] rdata;
    logic [1:0]                  rresp;
    logic                        rvalid;
    logic                        rready;
    logic [`SRAM_ADDR_WIDTH-1:0] awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [`SRAM_DATA_WIDTH-1:0] wdata;
    logic [`SRAM_STRB_WIDTH-1:0] wstrb;
    logic                        wvalid;
    logic                        wready;
    logic [1:0]                  bresp;
    logic                        bvalid;
    logic                        bready;

    // expected responses in issue order
    logic                        exp_write_q[$];
    logic [8*NAME_BYTES-1:0]     exp_name_q[$];
    logic [`SRAM_DATA_WIDTH-1:0] exp_data_q[$];
    logic [1:0]                  exp_resp_q[$];

    // handshake counts seen on the bus
    int                          ar_n;
    int                          aw_n;
    int                          w_n;
    int                          r_n;
    int                          b_n;
    int                          in_flight;
    bit                          r_held;
    bit                          b_held;
    logic [`SRAM_DATA_WIDTH-1:0] r_held_data;
    logic [1:0]                  r_held_resp;
    logic [1:0]                  b_held_resp;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    axi_lite_sram DUT (
        .clk     (clk),
        .reset   (reset),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1);
    endtask

    // ready seen high on a falling edge means transfer on the next rising edge
    task automatic issue_read(input logic [`SRAM_ADDR_WIDTH-1:0] addr);
        int   n;
        logic go;
        n       = 0;
        go      = 1'b0;
        araddr  = addr;
        arvalid = 1'b1;
        while (!go) begin
            go = arready;
            @(negedge clk);
            n++;
            if (!go && n > TIMEOUT) begin
                $display("AR channel never answered for address %h", addr);
                stop_on_error();
            end
        end
        arvalid = 1'b0;
    endtask

    // each half raised after its own lag, in cycles
    task automatic issue_write(input logic [`SRAM_ADDR_WIDTH-1:0] addr,
                               input logic [`SRAM_DATA_WIDTH-1:0] data,
                               input logic [`SRAM_STRB_WIDTH-1:0] strb,
                               input int aw_lag, input int w_lag);
        int   cyc;
        logic aw_done;
        logic w_done;
        logic aw_go;
        logic w_go;
        cyc     = 0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        while (!(aw_done && w_done)) begin
            if (!aw_done && cyc >= aw_lag) begin
                awaddr  = addr;
                awvalid = 1'b1;
            end
            if (!w_done && cyc >= w_lag) begin
                wdata  = data;
                wstrb  = strb;
                wvalid = 1'b1;
            end
            aw_go = awvalid && awready;
            w_go  = wvalid && wready;
            @(negedge clk);
            cyc++;
            if (aw_go) begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_go) begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
            if (!(aw_done && w_done) && cyc > TIMEOUT + aw_lag + w_lag) begin
                if (!aw_done) begin
                    $display("AW channel never answered for address %h", addr);
                end else begin
                    $display("W channel never answered for address %h", addr);
                end
                stop_on_error();
            end
        end
    endtask

    // compare one response with the oldest expected entry
    task automatic check_response(input logic is_write,
                                  input logic [`SRAM_DATA_WIDTH-1:0] data,
                                  input logic [1:0] resp);
        logic [8*NAME_BYTES-1:0] name;
        assert (exp_write_q.size() != 0) else begin
            $display("a response arrived with no transaction outstanding");
            stop_on_error();
        end
        name = exp_name_q[0];
        assert (exp_write_q[0] == is_write) else begin
            $display("FAIL %0s expected %0s actual %0s", name,
                     exp_write_q[0] ? "B" : "R", is_write ? "B" : "R");
            stop_on_error();
        end
        assert (resp == exp_resp_q[0]) else begin
            $display("FAIL %0s expected %h actual %h", name, exp_resp_q[0], resp);
            stop_on_error();
        end
        if (!is_write) begin
            assert (data == exp_data_q[0]) else begin
                $display("FAIL %0s expected %h actual %h", name, exp_data_q[0], data);
                stop_on_error();
            end
        end
        void'(exp_write_q.pop_front());
        void'(exp_name_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_resp_q.pop_front());
    endtask

    // bus monitor, values read here are the ones the edge samples
    always @(posedge clk) begin
        if (reset) begin
            ar_n      = 0;
            aw_n      = 0;
            w_n       = 0;
            r_n       = 0;
            b_n       = 0;
            in_flight = 0;
            r_held    = 1'b0;
            b_held    = 1'b0;
        end else begin
            // a stalled response stays put
            if (r_held) begin
                assert (rvalid && rdata == r_held_data && rresp == r_held_resp) else begin
                    $display("FAIL r_hold expected %h actual %h",
                             {1'b1, r_held_resp, r_held_data}, {rvalid, rresp, rdata});
                    stop_on_error();
                end
            end
            if (b_held) begin
                assert (bvalid && bresp == b_held_resp) else begin
                    $display("FAIL b_hold expected %h actual %h",
                             {1'b1, b_held_resp}, {bvalid, bresp});
                    stop_on_error();
                end
            end
            // pipeline full by handshake count
            if (in_flight == 4 && (rvalid || bvalid)) begin
                assert (!arready && !awready && !wready) else begin
                    $display("a ready was high with four transactions in flight");
                    stop_on_error();
                end
            end
            if (arvalid && arready) ar_n++;
            if (awvalid && awready) aw_n++;
            if (wvalid && wready) w_n++;
            if (rvalid && rready) begin
                check_response(1'b0, rdata, rresp);
                r_n++;
            end
            if (bvalid && bready) begin
                check_response(1'b1, '0, bresp);
                b_n++;
            end
            // a write counts once both halves are in
            in_flight = ar_n + ((aw_n < w_n) ? aw_n : w_n) - r_n - b_n;
            assert (in_flight <= 4) else begin
                $display("more than four transactions in flight");
                stop_on_error();
            end
            r_held      = rvalid && !rready;
            r_held_data = rdata;
            r_held_resp = rresp;
            b_held      = bvalid && !bready;
            b_held_resp = bresp;
        end
    end

    // random stretches of rready and bready low
    initial begin : backpressure
        int r_stall;
        int b_stall;
        r_stall = 0;
        b_stall = 0;
        rready  = 1'b0;
        bready  = 1'b0;
        forever begin
            @(negedge clk);
            if (r_stall > 0) begin
                rready = 1'b0;
                r_stall--;
            end else begin
                rready  = 1'b1;
                r_stall = ($urandom % 3 == 0) ? int'($urandom % 12) : 0;
            end
            if (b_stall > 0) begin
                bready = 1'b0;
                b_stall--;
            end else begin
                bready  = 1'b1;
                b_stall = ($urandom % 3 == 0) ? int'($urandom % 12) : 0;
            end
        end
    end

    initial begin : main_flow
        int                          fd;
        int                          fields;
        int                          n;
        string                       line;
        logic [7:0]                  op;
        logic [8*NAME_BYTES-1:0]     name;
        logic [`SRAM_ADDR_WIDTH-1:0] addr;
        logic [`SRAM_DATA_WIDTH-1:0] data;
        logic [`SRAM_DATA_WIDTH-1:0] exp_data;
        logic [`SRAM_STRB_WIDTH-1:0] strb;
        logic [1:0]                  exp_resp;
        void'($urandom(32'h48cfb0ea));
        reset   = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        repeat (15) @(negedge clk);
        // nothing offered while in reset
        assert (!arready && !awready && !wready && !rvalid && !bvalid) else begin
            $display("FAIL reset_idle expected %h actual %h", 5'b0,
                     {arready, awready, wready, rvalid, bvalid});
            stop_on_error();
        end
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen("bench/sram_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/sram_golden.txt");
            stop_on_error();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%s %s %h %h %h %h %h",
                             op, name, addr, data, strb, exp_data, exp_resp);
            if (fields != 7) begin
                $display("malformed golden line: %0s", line);
                stop_on_error();
            end
            // random gap between transactions
            repeat ($urandom % 4) @(negedge clk);
            exp_write_q.push_back(op != "R");
            exp_name_q.push_back(name);
            exp_data_q.push_back(exp_data);
            exp_resp_q.push_back(exp_resp);
            case (op)
                "R": issue_read(addr);
                "W": issue_write(addr, data, strb, 0, 0);
                "A": issue_write(addr, data, strb, 0, 5);
                "D": issue_write(addr, data, strb, 5, 0);
                default: begin
                    $display("unknown operation in golden line: %0s", line);
                    stop_on_error();
                end
            endcase
        end
        $fclose(fd);

        // drain the remaining responses
        n = 0;
        while (exp_write_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("%0s channel never answered for %0s",
                         exp_write_q[0] ? "B" : "R", exp_name_q[0]);
                stop_on_error();
            end
        end
        repeat (10) @(negedge clk);
        if (!rvalid && !bvalid) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("a response was still pending after the last transaction");
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

//--- axi_lite_sram.f
+incdir+source
source/sram_pkg.sv
source/sram_if.sv
source/axi_lite_accept.sv
source/access_delay.sv
source/sram_array.sv
source/axi_lite_respond.sv
source/axi_lite_sram.sv
bench/axi_lite_sram_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
TOP       := axi_lite_sram_tb
FILELIST  := axi_lite_sram.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/sram_golden.txt
# op name addr wdata wstrb exp_rdata exp_resp (hex, resp 0 okay, 2 slverr)
# op: W aw and w together, A aw before w, D w before aw, R read
W full_wr_0      00000000 11223344 f 00000000 0
R full_rd_0      00000000 00000000 0 11223344 0
W full_wr_1      000003fc deadbeef f 00000000 0
R full_rd_1      000003fc 00000000 0 deadbeef 0
W part_base      00000010 a5a5a5a5 f 00000000 0
W part_lo        00000010 000000c3 1 00000000 0
R part_rd_lo     00000010 00000000 0 a5a5a5c3 0
W part_mid       00000010 00ff0000 4 00000000 0
R part_rd_mid    00000010 00000000 0 a5ffa5c3 0
W part_odd       00000010 12345678 a 00000000 0
R part_rd_odd    00000010 00000000 0 12ff56c3 0
W oor_base       00000020 cafef00d f 00000000 0
W oor_wr         00000420 ffffffff f 00000000 2
R oor_rd         00000420 00000000 0 00000000 2
R oor_rd_hi      80000020 00000000 0 00000000 2
W oor_wr_hi      80000020 12121212 f 00000000 2
R oor_check      00000020 00000000 0 cafef00d 0
A aw_first       00000040 0badf00d f 00000000 0
D w_first        00000044 feedface f 00000000 0
R aw_first_rd    00000040 00000000 0 0badf00d 0
R w_first_rd     00000044 00000000 0 feedface 0
A aw_first_part  00000040 00770000 4 00000000 0
R aw_part_rd     00000040 00000000 0 0b77f00d 0
W q_wr_0         00000100 01010101 f 00000000 0
W q_wr_1         00000104 02020202 f 00000000 0
W q_wr_2         00000108 03030303 f 00000000 0
R q_rd_0         00000100 00000000 0 01010101 0
R q_rd_2         00000108 00000000 0 03030303 0
R q_rd_1         00000104 00000000 0 02020202 0
D q_wr_3         0000010c 04040404 f 00000000 0
R q_rd_3         0000010c 00000000 0 04040404 0
R q_rd_first     00000000 00000000 0 11223344 0
